// ==== bit_packer.sv ====
`timescale 1ns/1ns

module bit_packer (
    input  logic                   clk,
    input  logic                   reset,
    input  edge_pkg::edge_stream_t i_edge,
    output logic                   o_out_valid,
    output logic [7:0]             o_out_byte,
    output logic                   o_frame_done
);
    import edge_pkg::*;

    logic [7:0] shift_reg;
    logic [2:0] bit_cnt;
    logic [7:0] next_byte;

    // New bit enters at the top, so the first pixel ends at bit 0
    assign next_byte = {i_edge.edge_bit, shift_reg[7:1]};

    always_ff @(posedge clk) begin
        if (i_edge.valid)
            shift_reg <= next_byte;
    end

    always_ff @(posedge clk) begin
        if (reset)
            bit_cnt <= 3'd0;
        else if (i_edge.valid)
            bit_cnt <= bit_cnt + 1'b1;  // Wraps every eight bits
    end

    always_ff @(posedge clk) begin
        if (i_edge.valid && bit_cnt == 3'd7)
            o_out_byte <= next_byte;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_out_valid  <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            o_out_valid  <= i_edge.valid && (bit_cnt == 3'd7);
            o_frame_done <= i_edge.valid && (bit_cnt == 3'd7) && i_edge.last;
        end
    end

endmodule

// ==== edge_filter.sv ====
`timescale 1ns/1ns

module edge_filter (
    input  logic                    clk,
    input  logic                    reset,
    input  edge_pkg::pixel_stream_t i_pix,
    output edge_pkg::edge_stream_t  o_edge
);
    import edge_pkg::*;

    logic [9:0]        grey_sum;
    logic [7:0]        grey;
    logic [7:0]        prev_grey;
    logic [7:0]        diff;
    logic              is_edge;
    logic [ADDR_W-1:0] pix_cnt;

    // (r + 2g + b) / 4, truncated
    assign grey_sum = {2'b00, i_pix.rgb.r} + {1'b0, i_pix.rgb.g, 1'b0} + {2'b00, i_pix.rgb.b};
    assign grey     = grey_sum[9:2];

    assign diff    = (grey > prev_grey) ? (grey - prev_grey) : (prev_grey - grey);
    assign is_edge = !i_pix.first && (diff > EDGE_TH);  // No left neighbour at column 0

    always_ff @(posedge clk) begin
        if (i_pix.valid)
            prev_grey <= grey;
    end

    // Pixel position within the frame
    always_ff @(posedge clk) begin
        if (reset)
            pix_cnt <= '0;
        else if (i_pix.valid)
            pix_cnt <= pix_cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_edge <= '0;
        end else begin
            o_edge.valid    <= i_pix.valid;
            o_edge.last     <= i_pix.valid && (pix_cnt == ADDR_W'(FRAME_PIXELS - 1));
            o_edge.edge_bit <= i_pix.valid && is_edge;
        end
    end

endmodule

// ==== edge_pkg.sv ====
package edge_pkg;

    // Frame geometry in pixels
    localparam int FRAME_W      = 16;
    localparam int FRAME_H      = 8;
    localparam int FRAME_PIXELS = FRAME_W * FRAME_H;
    localparam int ADDR_W       = $clog2(FRAME_PIXELS);

    // Edge when |grey - left grey| is strictly above this
    localparam int EDGE_TH = 24;

    // One pixel, r arrives first on the byte stream
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Frame buffer write port
    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        rgb_t              rgb;
    } pixel_wr_t;

    // Raster-order pixel stream out of the reader
    typedef struct packed {
        logic valid;
        logic first;  // Column 0 of a row
        rgb_t rgb;
    } pixel_stream_t;

    // One edge bit per pixel
    typedef struct packed {
        logic valid;
        logic last;   // Last pixel of the frame
        logic edge_bit;
    } edge_stream_t;

endpackage

// ==== edge_top.sv ====
`timescale 1ns/1ns

module edge_top (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_byte_valid,
    input  logic [7:0] i_byte,
    output logic       o_out_valid,
    output logic [7:0] o_out_byte,
    output logic       o_frame_done
);
    import edge_pkg::*;

    pixel_wr_t         wr;
    logic              frame_end;
    logic [ADDR_W-1:0] rd_addr;
    rgb_t              rd_data;
    pixel_stream_t     pix;
    edge_stream_t      edge_s;

    // Byte stream to pixel writes
    pixel_assembler u_pixel_assembler (
        .clk         (clk),
        .reset       (reset),
        .i_byte_valid(i_byte_valid),
        .i_byte      (i_byte),
        .o_wr        (wr),
        .o_frame_end (frame_end)
    );

    frame_buffer u_frame_buffer (
        .clk      (clk),
        .i_wr     (wr),
        .i_rd_addr(rd_addr),
        .o_rd_data(rd_data)
    );

    // Scan starts on frame end
    frame_reader u_frame_reader (
        .clk      (clk),
        .reset    (reset),
        .i_start  (frame_end),
        .o_rd_addr(rd_addr),
        .i_rd_data(rd_data),
        .o_pix    (pix)
    );

    edge_filter u_edge_filter (
        .clk   (clk),
        .reset (reset),
        .i_pix (pix),
        .o_edge(edge_s)
    );

    bit_packer u_bit_packer (
        .clk         (clk),
        .reset       (reset),
        .i_edge      (edge_s),
        .o_out_valid (o_out_valid),
        .o_out_byte  (o_out_byte),
        .o_frame_done(o_frame_done)
    );

endmodule

// ==== edge_top_assert.sv ====
`timescale 1ns/1ns

module edge_top_assert (
    input logic clk,
    input logic reset,
    input logic i_out_valid,
    input logic i_frame_done
);

    logic reset_q = 1'b0;  // Reset seen at the previous edge

    always_ff @(posedge clk) begin
        reset_q <= reset;
    end

    // Strobes quiet once reset has been applied
    reset_quiet: assert property (
        @(posedge clk) (reset && reset_q) |-> (!i_out_valid && !i_frame_done)
    ) else $error("Output strobe high while reset is held");

    done_with_byte: assert property (
        @(posedge clk) disable iff (reset)
        i_frame_done |-> i_out_valid
    ) else $error("Frame done without an output byte strobe");

    // Eight edge bits per byte, so at most one byte every eight cycles
    byte_spacing: assert property (
        @(posedge clk) disable iff (reset)
        i_out_valid |-> !($past(i_out_valid, 1) || $past(i_out_valid, 2) ||
                          $past(i_out_valid, 3) || $past(i_out_valid, 4) ||
                          $past(i_out_valid, 5) || $past(i_out_valid, 6) ||
                          $past(i_out_valid, 7))
    ) else $error("Output byte strobes closer than eight cycles");

endmodule

// ==== frame_buffer.sv ====
`timescale 1ns/1ns

module frame_buffer (
    input  logic                       clk,
    input  edge_pkg::pixel_wr_t        i_wr,
    input  logic [edge_pkg::ADDR_W-1:0] i_rd_addr,
    output edge_pkg::rgb_t             o_rd_data
);
    import edge_pkg::*;

    rgb_t mem [FRAME_PIXELS];

    // Write port from the assembler
    always_ff @(posedge clk) begin
        if (i_wr.we)
            mem[i_wr.addr] <= i_wr.rgb;
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

// ==== frame_reader.sv ====
`timescale 1ns/1ns

module frame_reader (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_start,
    output logic [edge_pkg::ADDR_W-1:0] o_rd_addr,
    input  edge_pkg::rgb_t              i_rd_data,
    output edge_pkg::pixel_stream_t     o_pix
);
    import edge_pkg::*;

    logic [$clog2(FRAME_W)-1:0] x_cnt;
    logic [$clog2(FRAME_H)-1:0] y_cnt;
    logic                       reading;
    logic                       last_addr;
    logic                       s1_valid;  // Lines up with memory data
    logic                       s1_first;

    assign last_addr = (x_cnt == FRAME_W - 1) && (y_cnt == FRAME_H - 1);

    always_ff @(posedge clk) begin
        if (reset)
            reading <= 1'b0;
        else if (i_start)
            reading <= 1'b1;
        else if (last_addr)
            reading <= 1'b0;
    end

    // Raster scan counters, parked at zero when idle
    always_ff @(posedge clk) begin
        if (reset || !reading) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (x_cnt == FRAME_W - 1) begin
            x_cnt <= '0;
            y_cnt <= y_cnt + 1'b1;
        end else begin
            x_cnt <= x_cnt + 1'b1;
        end
    end

    assign o_rd_addr = ADDR_W'(y_cnt * FRAME_W + x_cnt);

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid    <= 1'b0;
            s1_first    <= 1'b0;
            o_pix.valid <= 1'b0;
            o_pix.first <= 1'b0;
        end else begin
            s1_valid    <= reading;
            s1_first    <= reading && (x_cnt == '0);
            o_pix.valid <= s1_valid;
            o_pix.first <= s1_first;
        end
    end

    // Pixel data zeroed outside the frame
    always_ff @(posedge clk) begin
        o_pix.rgb <= s1_valid ? i_rd_data : '0;
    end

endmodule

// ==== pixel_assembler.sv ====
`timescale 1ns/1ns

module pixel_assembler (
    input  logic                clk,
    input  logic                reset,
    input  logic                i_byte_valid,
    input  logic [7:0]          i_byte,
    output edge_pkg::pixel_wr_t o_wr,
    output logic                o_frame_end
);
    import edge_pkg::*;

    logic [1:0]        phase;    // 0 r, 1 g, 2 b
    logic [7:0]        r_hold;
    logic [7:0]        g_hold;
    logic [ADDR_W-1:0] wr_addr;
    logic              b_byte;
    logic              last_pix;

    assign b_byte   = i_byte_valid && (phase == 2'd2);
    assign last_pix = (wr_addr == ADDR_W'(FRAME_PIXELS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            phase   <= 2'd0;
            wr_addr <= '0;
        end else if (i_byte_valid) begin
            if (phase == 2'd2) begin
                phase <= 2'd0;
                if (last_pix)
                    wr_addr <= '0;  // Next frame
                else
                    wr_addr <= wr_addr + 1'b1;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // Colour holding registers
    always_ff @(posedge clk) begin
        if (i_byte_valid && phase == 2'd0)
            r_hold <= i_byte;
        if (i_byte_valid && phase == 2'd1)
            g_hold <= i_byte;
    end

    always_ff @(posedge clk) begin
        o_wr.addr  <= wr_addr;
        o_wr.rgb.r <= r_hold;
        o_wr.rgb.g <= g_hold;
        o_wr.rgb.b <= i_byte;
        if (reset) begin
            o_wr.we     <= 1'b0;
            o_frame_end <= 1'b0;
        end else begin
            o_wr.we     <= b_byte;
            o_frame_end <= b_byte && last_pix;  // Same cycle as last write
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then search the log for the failure line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_edge_top -f sources.f \
    && ./obj_dir/Vtb_edge_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q ">>> FAIL" sim.log \
    && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

// ==== sources.f ====
edge_pkg.sv
pixel_assembler.sv
frame_buffer.sv
frame_reader.sv
edge_filter.sv
bit_packer.sv
edge_top.sv
edge_top_assert.sv
tb_edge_top.sv

// ==== tb_edge_top.sv ====
`timescale 1ns/1ns

module tb_edge_top;
    import edge_pkg::*;

    localparam int OUT_BYTES = FRAME_PIXELS / 8;
    localparam int NUM_TESTS = 8;

    typedef enum logic [2:0] {SOLID, VSTRIPE, HSTRIPE, RANDOM, RAMP} kind_t;

    typedef struct packed {
        kind_t      kind;
        logic [7:0] width;     // Stripe width, step for RAMP
        logic [7:0] contrast;  // Grey step between stripes
        logic [7:0] gap;       // Idle cycles after each byte
    } test_row_t;

    test_row_t tests [NUM_TESTS] = '{
        '{SOLID,   8'd0, 8'd0,   8'd0},
        '{VSTRIPE, 8'd4, 8'd40,  8'd0},
        '{VSTRIPE, 8'd2, 8'd24,  8'd1},  // Exactly at threshold
        '{VSTRIPE, 8'd3, 8'd25,  8'd0},  // One above threshold
        '{HSTRIPE, 8'd2, 8'd100, 8'd0},
        '{RANDOM,  8'd0, 8'd0,   8'd0},
        '{RAMP,    8'd9, 8'd0,   8'd2},
        '{RANDOM,  8'd0, 8'd0,   8'd3}
    };

    logic       clk;
    logic       reset;
    logic       i_byte_valid;
    logic [7:0] i_byte;
    logic       o_out_valid;
    logic [7:0] o_out_byte;
    logic       o_frame_done;

    integer     seed;
    int         errors;
    int         tests_failed;
    int         out_count;
    bit         done_seen;
    rgb_t       frame [FRAME_PIXELS];
    logic [7:0] expected [OUT_BYTES];

    edge_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .i_byte_valid(i_byte_valid),
        .i_byte      (i_byte),
        .o_out_valid (o_out_valid),
        .o_out_byte  (o_out_byte),
        .o_frame_done(o_frame_done)
    );

    bind edge_top edge_top_assert u_edge_top_assert (
        .clk         (clk),
        .reset       (reset),
        .i_out_valid (o_out_valid),
        .i_frame_done(o_frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic rgb_t grey_pixel(input logic [7:0] v);
        rgb_t p;
        p.r = v;
        p.g = v;
        p.b = v;
        return p;
    endfunction

    // Grey value as (r + 2g + b) / 4
    function automatic int grey_of(input rgb_t p);
        return (int'(p.r) + 2 * int'(p.g) + int'(p.b)) / 4;
    endfunction

    task automatic build_frame(input test_row_t row);
        int          x;
        int          y;
        logic [7:0]  base;
        logic [31:0] rnd;
        base = 8'd60;
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            x = i % FRAME_W;
            y = i / FRAME_W;
            case (row.kind)
                SOLID:   frame[i] = grey_pixel(8'h80);
                VSTRIPE: frame[i] = grey_pixel(((x / row.width) % 2) ? 8'(base + row.contrast) : base);
                HSTRIPE: frame[i] = grey_pixel(((y / row.width) % 2) ? 8'(base + row.contrast) : base);
                RANDOM: begin
                    rnd = $random(seed);
                    frame[i] = rnd[23:0];
                end
                default: begin
                    frame[i].r = 8'(x * row.width);
                    frame[i].g = 8'(y * row.width);
                    frame[i].b = 8'(i);
                end
            endcase
        end
    endtask

    // Edge bit per pixel, first pixel of each byte at bit 0
    task automatic compute_expected();
        int g_cur;
        int g_left;
        int diff;
        for (int i = 0; i < OUT_BYTES; i++)
            expected[i] = 8'h00;
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            if (i % FRAME_W != 0) begin
                g_cur  = grey_of(frame[i]);
                g_left = grey_of(frame[i - 1]);
                diff   = (g_cur > g_left) ? g_cur - g_left : g_left - g_cur;
                if (diff > EDGE_TH)
                    expected[i / 8][i % 8] = 1'b1;
            end
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic send_byte(input logic [7:0] b, input int gap);
        i_byte_valid = 1'b1;
        i_byte       = b;
        @(negedge clk);
        i_byte_valid = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic drive_frame(input int gap);
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            send_byte(frame[i].r, gap);
            send_byte(frame[i].g, gap);
            send_byte(frame[i].b, gap);
        end
    endtask

    task automatic check_byte(input int idx, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch: o_out_byte[%0d] got %h expected %h", idx, got, exp);
        end
    endtask

    task automatic check_frame_done(input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("Mismatch: o_frame_done byte count got %h expected %h", got, exp);
        end
    endtask

    // Outputs settle after the rising edge, sampled on the falling one
    task automatic collect_frame();
        out_count = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(negedge clk);
            if (o_out_valid) begin
                if (out_count < OUT_BYTES) begin
                    check_byte(out_count, o_out_byte, expected[out_count]);
                end else begin
                    errors++;
                    $display("Extra output byte %0d beyond the end of the frame", out_count);
                end
                out_count++;
                if (o_frame_done) begin
                    done_seen = 1'b1;
                    check_frame_done(out_count, OUT_BYTES);
                end
            end else if (o_frame_done) begin
                errors++;
                $display("Frame done flag raised without an output byte");
            end
        end
    endtask

    task automatic run_test(input int t);
        test_row_t row;
        kind_t     kind;
        int        errors_before;
        row           = tests[t];
        kind          = row.kind;
        errors_before = errors;
        build_frame(row);
        compute_expected();
        fork
            drive_frame(int'(row.gap));
            collect_frame();
        join
        if (errors == errors_before) begin
            $display("Test %0d %s gap %0d: ok, %0d bytes", t, kind.name(), row.gap, out_count);
        end else begin
            tests_failed++;
            $display("Test %0d %s gap %0d: %0d errors", t, kind.name(), row.gap,
                     errors - errors_before);
        end
    endtask

    initial begin
        seed         = 32'hd6a0;
        errors       = 0;
        tests_failed = 0;
        reset        = 1'b1;
        i_byte_valid = 1'b0;
        i_byte       = 8'h00;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("Tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // Input time of every frame plus room for the scan
    initial begin : watchdog
        int limit;
        limit = 0;
        @(negedge reset);
        for (int t = 0; t < NUM_TESTS; t++)
            limit += 3 * FRAME_PIXELS * (int'(tests[t].gap) + 1) + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", limit);
        $display(">>> FAIL");
        $finish;
    end

endmodule
